/* source/fe_pkg.sv */
package fe_pkg;

  // pc widths
  localparam int pc_width_lp = 32;
  typedef logic [pc_width_lp-1:0] addr_t;

  // bht index is pc[9:2], 256 counters
  localparam int bht_idx_width_lp = 8;
  localparam int bht_els_lp = 2**bht_idx_width_lp;
  typedef logic [bht_idx_width_lp-1:0] bht_idx_t;

  // btb index is pc[7:2], 64 entries
  localparam int btb_idx_width_lp = 6;
  localparam int btb_els_lp = 2**btb_idx_width_lp;
  typedef logic [btb_idx_width_lp-1:0] btb_idx_t;

  // btb tag is pc[31:8]
  localparam int btb_tag_width_lp = pc_width_lp - btb_idx_width_lp - 2;
  typedef logic [btb_tag_width_lp-1:0] btb_tag_t;

  // 2-bit counter, msb is direction, lsb set means weak
  typedef enum logic [1:0] {
    strong_nt = 2'b00,
    weak_nt   = 2'b01,
    strong_t  = 2'b10,
    weak_t    = 2'b11
  } ctr_e;

  localparam ctr_e ctr_reset_lp = weak_nt;

  // fall-through step
  localparam addr_t inst_bytes_lp = 32'd4;

  typedef struct packed {
    logic  v;           // lookup strobe
    addr_t pc;          // fetch pc
  } lookup_s;

  typedef struct packed {
    logic  v;           // resolved branch strobe
    addr_t pc;          // branch pc
    logic  taken;       // actual direction
    addr_t tgt;         // actual target
    logic  pred_taken;  // direction that was predicted
  } update_s;

  typedef struct packed {
    logic  v;           // record valid, one cycle
    addr_t pc;          // pc that was looked up
    logic  taken;       // predicted direction
    logic  btb_hit;     // target buffer holds a target
    addr_t next_pc;     // predicted next fetch pc
  } pred_s;

endpackage

/* source/fe_bht.sv */
module fe_bht
  import fe_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  bht_idx_t idx_r_i,    // lookup index
  input  bht_idx_t idx_w_i,    // update index
  input  logic     w_v_i,      // train strobe
  input  logic     correct_i,  // prediction was right
  output logic     predict_o   // predicted direction
);

  ctr_e ctr_mem_r [bht_els_lp];  // counter array
  ctr_e ctr_rd;                  // counter at read index
  ctr_e ctr_cur;                 // counter at write index
  ctr_e ctr_nxt;                 // trained value

  // combinational read, old state on a same-cycle write
  assign ctr_rd    = ctr_mem_r[idx_r_i];
  assign predict_o = ctr_rd[1];

  assign ctr_cur = ctr_mem_r[idx_w_i];

  // saturating update
  always_comb
  begin
    ctr_nxt = ctr_cur;
    if (correct_i)
    begin
      // right guess, harden toward the same direction
      case (ctr_cur)
        weak_nt:  ctr_nxt = strong_nt;
        weak_t:   ctr_nxt = strong_t;
        default:  ctr_nxt = ctr_cur;   // strong stays
      endcase
    end
    else
    begin
      // wrong guess, step toward the other direction
      case (ctr_cur)
        strong_nt: ctr_nxt = weak_nt;
        weak_nt:   ctr_nxt = weak_t;   // flips direction
        strong_t:  ctr_nxt = weak_t;
        weak_t:    ctr_nxt = weak_nt;  // flips direction
        default:   ctr_nxt = ctr_reset_lp;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      // all counters weakly not taken
      for (int i = 0; i < bht_els_lp; i++)
        ctr_mem_r[i] <= ctr_reset_lp;
    end
    else if (w_v_i)
    begin
      ctr_mem_r[idx_w_i] <= ctr_nxt;
    end
  end

  // an x index would corrupt an unknown counter
  a_w_idx_known: assert property (@(posedge clk_i) disable iff (reset_i)
    w_v_i |-> !$isunknown(idx_w_i))
    else $error("bht write index unknown");

endmodule

/* source/fe_btb.sv */
module fe_btb
  import fe_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  btb_idx_t idx_r_i,   // lookup index
  input  btb_tag_t tag_r_i,   // lookup tag
  input  btb_idx_t idx_w_i,   // fill index
  input  btb_tag_t tag_w_i,   // fill tag
  input  addr_t    tgt_w_i,   // fill target
  input  logic     w_v_i,     // fill strobe, taken branches only
  output logic     hit_o,     // valid entry with matching tag
  output addr_t    tgt_o      // stored target at read index
);

  logic [btb_els_lp-1:0] valid_r;         // per entry valid
  btb_tag_t              tag_mem_r [btb_els_lp];
  addr_t                 tgt_mem_r [btb_els_lp];

  logic     rd_valid;
  btb_tag_t rd_tag;

  // read side is pure combinational
  assign rd_valid = valid_r[idx_r_i];
  assign rd_tag   = tag_mem_r[idx_r_i];
  assign tgt_o    = tgt_mem_r[idx_r_i];

  // tag compare, only trusted when the entry is valid
  assign hit_o = rd_valid && (rd_tag == tag_r_i);

  // valid bits are the only reset state
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      valid_r <= '0;
    end
    else if (w_v_i)
    begin
      valid_r[idx_w_i] <= 1'b1;
    end
  end

  // tag and target payload
  // direct mapped, a new branch at the same index evicts the old one
  always_ff @(posedge clk_i)
  begin
    if (w_v_i && !reset_i)
    begin
      tag_mem_r[idx_w_i] <= tag_w_i;
      tgt_mem_r[idx_w_i] <= tgt_w_i;
    end
  end

  // targets come from resolved branches, must be word aligned
  a_tgt_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
    hit_o |-> (tgt_o[1:0] == 2'b00))
    else $error("btb hit with misaligned target %h", tgt_o);

endmodule

/* source/fe_pred_ctrl.sv */
module fe_pred_ctrl
  import fe_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  lookup_s  lookup_i,       // fetch side request
  input  update_s  update_i,       // back end resolution
  output pred_s    pred_o,         // registered prediction record

  output bht_idx_t bht_idx_r_o,
  output bht_idx_t bht_idx_w_o,
  output logic     bht_w_v_o,
  output logic     bht_correct_o,
  input  logic     bht_predict_i,

  output btb_idx_t btb_idx_r_o,
  output btb_tag_t btb_tag_r_o,
  output btb_idx_t btb_idx_w_o,
  output btb_tag_t btb_tag_w_o,
  output addr_t    btb_tgt_w_o,
  output logic     btb_w_v_o,
  input  logic     btb_hit_i,
  input  addr_t    btb_tgt_i
);

  // pc slice bounds
  localparam int bht_lo_lp = 2;
  localparam int bht_hi_lp = bht_idx_width_lp + 1;    // pc[9:2]
  localparam int btb_hi_lp = btb_idx_width_lp + 1;    // pc[7:2]
  localparam int tag_lo_lp = btb_idx_width_lp + 2;    // pc[31:8]

  addr_t lookup_next_pc;   // next pc chosen this cycle
  logic  lookup_redirect;  // taken and target known

  logic  pred_v_r;         // lookup strobe delayed one cycle
  addr_t pred_pc_r;
  logic  pred_taken_r;
  logic  pred_hit_r;
  addr_t pred_next_pc_r;

  // lookup side table reads
  assign bht_idx_r_o = lookup_i.pc[bht_hi_lp:bht_lo_lp];
  assign btb_idx_r_o = lookup_i.pc[btb_hi_lp:bht_lo_lp];
  assign btb_tag_r_o = lookup_i.pc[pc_width_lp-1:tag_lo_lp];

  // update side, counter trained on every resolved branch
  assign bht_idx_w_o   = update_i.pc[bht_hi_lp:bht_lo_lp];
  assign bht_w_v_o     = update_i.v;
  assign bht_correct_o = (update_i.taken == update_i.pred_taken);

  // target buffer filled on taken branches only
  assign btb_idx_w_o = update_i.pc[btb_hi_lp:bht_lo_lp];
  assign btb_tag_w_o = update_i.pc[pc_width_lp-1:tag_lo_lp];
  assign btb_tgt_w_o = update_i.tgt;
  assign btb_w_v_o   = update_i.v && update_i.taken;

  // redirect needs both a taken guess and a stored target
  assign lookup_redirect = bht_predict_i && btb_hit_i;
  assign lookup_next_pc  = lookup_redirect ? btb_tgt_i : (lookup_i.pc + inst_bytes_lp);

  // record valid, cleared in reset
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      pred_v_r <= 1'b0;
    else
      pred_v_r <= lookup_i.v;
  end

  // record payload, loaded per lookup
  always_ff @(posedge clk_i)
  begin
    if (lookup_i.v)
    begin
      pred_pc_r      <= lookup_i.pc;
      pred_taken_r   <= bht_predict_i;
      pred_hit_r     <= btb_hit_i;
      pred_next_pc_r <= lookup_next_pc;
    end
  end

  always_comb
  begin
    pred_o.v       = pred_v_r;
    pred_o.pc      = pred_pc_r;
    pred_o.taken   = pred_taken_r;
    pred_o.btb_hit = pred_hit_r;
    pred_o.next_pc = pred_next_pc_r;
  end

  // fixed one cycle latency, one record per lookup and none otherwise
  a_pred_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    pred_o.v == $past(lookup_i.v && !reset_i))
    else $error("prediction valid out of step with lookup strobe");

  // strobes must be clean once out of reset
  a_strobe_known: assert property (@(posedge clk_i) disable iff (reset_i)
    !$isunknown({lookup_i.v, update_i.v}))
    else $error("lookup or update strobe unknown");

endmodule

/* source/fe_predictor_top.sv */
module fe_predictor_top
  import fe_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  lookup_s lookup_i,   // fetch pc strobe
  input  update_s update_i,   // resolved branch strobe
  output pred_s   pred_o      // prediction, one cycle after lookup
);

  // bht links
  bht_idx_t bht_idx_r;
  bht_idx_t bht_idx_w;
  logic     bht_w_v;
  logic     bht_correct;
  logic     bht_predict;

  // btb links
  btb_idx_t btb_idx_r;
  btb_tag_t btb_tag_r;
  btb_idx_t btb_idx_w;
  btb_tag_t btb_tag_w;
  addr_t    btb_tgt_w;
  logic     btb_w_v;
  logic     btb_hit;
  addr_t    btb_tgt;

  fe_pred_ctrl i_ctrl (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .lookup_i      (lookup_i),
    .update_i      (update_i),
    .pred_o        (pred_o),
    .bht_idx_r_o   (bht_idx_r),
    .bht_idx_w_o   (bht_idx_w),
    .bht_w_v_o     (bht_w_v),
    .bht_correct_o (bht_correct),
    .bht_predict_i (bht_predict),
    .btb_idx_r_o   (btb_idx_r),
    .btb_tag_r_o   (btb_tag_r),
    .btb_idx_w_o   (btb_idx_w),
    .btb_tag_w_o   (btb_tag_w),
    .btb_tgt_w_o   (btb_tgt_w),
    .btb_w_v_o     (btb_w_v),
    .btb_hit_i     (btb_hit),
    .btb_tgt_i     (btb_tgt)
  );

  // direction table
  fe_bht i_bht (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .idx_r_i   (bht_idx_r),
    .idx_w_i   (bht_idx_w),
    .w_v_i     (bht_w_v),
    .correct_i (bht_correct),
    .predict_o (bht_predict)
  );

  // target table
  fe_btb i_btb (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .idx_r_i (btb_idx_r),
    .tag_r_i (btb_tag_r),
    .idx_w_i (btb_idx_w),
    .tag_w_i (btb_tag_w),
    .tgt_w_i (btb_tgt_w),
    .w_v_i   (btb_w_v),
    .hit_o   (btb_hit),
    .tgt_o   (btb_tgt)
  );

endmodule

/* bench/fe_predictor_tb.sv */
module fe_predictor_tb
  import fe_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // one expected record and the cycle it is due on pred_o
  typedef struct packed {
    pred_s rec;
    int    due;
  } exp_s;

  logic    clk_i;
  logic    reset_i;
  lookup_s lookup;
  update_s update;
  pred_s   pred;

  // reference copies of both tables
  ctr_e     ctr_m     [256];
  logic     btb_v_m   [64];
  btb_tag_t btb_tag_m [64];
  addr_t    btb_tgt_m [64];

  exp_s   exp_q [$];    // records still owed by the DUT
  exp_s   cmp_e;
  addr_t  pool [8];     // colliding pcs for the random mix
  int     cyc;          // posedge count
  int     err_cnt;
  int     check_cnt;
  int     test_cnt;
  int     test_err0;    // error count when the test started
  integer seed;

  fe_predictor_top i_fe_predictor_top (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .lookup_i (lookup),
    .update_i (update),
    .pred_o   (pred)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;   // 4 ns period
  end

  always @(posedge clk_i)
    cyc <= cyc + 1;

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    check_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  // weak states harden when right, any state steps toward the other side when wrong
  function automatic ctr_e trained(input ctr_e c, input logic correct);
    ctr_e n;
    if (correct)
      n = c[0] ? ctr_e'({c[1], 1'b0}) : c;   // drop the weak bit
    else
    begin
      case (c)
        strong_nt: n = weak_nt;
        weak_nt:   n = weak_t;
        strong_t:  n = weak_t;
        default:   n = weak_nt;   // weak_t
      endcase
    end
    return n;
  endfunction

  // expected record from the model as it stands now
  function automatic pred_s ref_pred(input addr_t pc);
    pred_s    p;
    bht_idx_t bi;
    btb_idx_t ti;
    bi = pc[9:2];
    ti = pc[7:2];
    p.v       = 1'b1;
    p.pc      = pc;
    p.taken   = ctr_m[bi][1];                                  // msb is direction
    p.btb_hit = btb_v_m[ti] && (btb_tag_m[ti] == pc[31:8]);
    p.next_pc = (p.taken && p.btb_hit) ? btb_tgt_m[ti] : pc + 32'd4;
    return p;
  endfunction

  task automatic model_reset();
    for (int i = 0; i < 256; i++)
      ctr_m[i] = weak_nt;
    for (int i = 0; i < 64; i++)
    begin
      btb_v_m[i]   = 1'b0;
      btb_tag_m[i] = '0;
      btb_tgt_m[i] = '0;
    end
  endtask

  task automatic model_update(input update_s u);
    bht_idx_t bi;
    btb_idx_t ti;
    bi = u.pc[9:2];
    ti = u.pc[7:2];
    ctr_m[bi] = trained(ctr_m[bi], u.taken == u.pred_taken);
    if (u.taken)   // target only kept for taken branches
    begin
      btb_v_m[ti]   = 1'b1;
      btb_tag_m[ti] = u.pc[31:8];
      btb_tgt_m[ti] = u.tgt;
    end
  endtask

  function automatic lookup_s look_req(input addr_t pc);
    lookup_s l;
    l.v  = 1'b1;
    l.pc = pc;
    return l;
  endfunction

  function automatic update_s branch_upd(input addr_t pc, input logic taken,
                                         input addr_t tgt, input logic pred_taken);
    update_s u;
    u.v          = 1'b1;
    u.pc         = pc;
    u.taken      = taken;
    u.tgt        = tgt;
    u.pred_taken = pred_taken;
    return u;
  endfunction

  // one cycle of stimulus, called at a falling edge
  task automatic drive_cycle(input lookup_s lk, input update_s up);
    exp_s e;
    lookup = lk;
    update = up;
    // lookup reads the state before this cycle's update
    if (lk.v)
    begin
      e.rec = ref_pred(lk.pc);
      e.due = cyc + 1;   // visible after the next rising edge
      exp_q.push_back(e);
    end
    if (up.v)
      model_update(up);
    @(negedge clk_i);
    lookup = '0;
    update = '0;
  endtask

  task automatic wait_drain(input string what);
    int n;
    n = 0;
    while (exp_q.size() > 0 && n < 20)
    begin
      @(negedge clk_i);
      n++;
    end
    if (exp_q.size() > 0)
    begin
      $display("timeout: %s still owed %0d predictions after 20 cycles", what,
               exp_q.size());
      err_cnt++;
      exp_q.delete();
    end
  endtask

  task automatic end_test(input string name);
    wait_drain(name);
    test_cnt++;
    $display("test %0d %s done, %0d errors", test_cnt, name, err_cnt - test_err0);
    test_err0 = err_cnt;
  endtask

  // pred is stable at the falling edge
  always @(negedge clk_i)
  begin
    if (!reset_i)
    begin
      if (exp_q.size() > 0 && exp_q[0].due == cyc)
      begin
        cmp_e = exp_q.pop_front();
        check_val("pred_o.v", 32'(pred.v), 32'd1);
        check_val("pred_o.pc", pred.pc, cmp_e.rec.pc);
        check_val("pred_o.taken", 32'(pred.taken), 32'(cmp_e.rec.taken));
        check_val("pred_o.btb_hit", 32'(pred.btb_hit), 32'(cmp_e.rec.btb_hit));
        check_val("pred_o.next_pc", pred.next_pc, cmp_e.rec.next_pc);
      end
      else
        check_val("pred_o.v", 32'(pred.v), 32'd0);   // no lookup last cycle
    end
  end

  task automatic reset_state_test();
    addr_t r;
    for (int i = 0; i < 6; i++)
    begin
      r = $random(seed);
      drive_cycle(look_req({r[31:2], 2'b00}), '0);
      if (i % 2 == 1)
        drive_cycle('0, '0);   // idle gap so pred must drop
    end
    end_test("reset_state");
  endtask

  // each lookup's record is on pred_o when drive_cycle returns
  task automatic counter_train_test();
    addr_t a;
    addr_t t;
    a = 32'h0000_1040;
    t = 32'h0000_2000;
    drive_cycle('0, branch_upd(a, 1'b1, t, 1'b0));   // wrong guess gives weak_t
    drive_cycle(look_req(a), '0);
    check_val("pred_o.taken after 1", 32'(pred.taken), 32'd1);
    drive_cycle('0, branch_upd(a, 1'b1, t, 1'b1));   // right guess gives strong_t
    drive_cycle(look_req(a), '0);
    check_val("pred_o.taken after 2", 32'(pred.taken), 32'd1);
    drive_cycle('0, branch_upd(a, 1'b0, t, 1'b1));   // wrong guess back to weak_t
    drive_cycle(look_req(a), '0);
    check_val("pred_o.taken after 3", 32'(pred.taken), 32'd1);
    drive_cycle('0, branch_upd(a, 1'b0, t, 1'b1));   // wrong again to weak_nt
    drive_cycle(look_req(a), '0);
    check_val("pred_o.taken after 4", 32'(pred.taken), 32'd0);
    end_test("counter_training");
  endtask

  task automatic btb_target_test();
    addr_t a;
    addr_t b;
    a = 32'h0000_2080;   // btb index 0x20, tag 0x20
    b = 32'h0000_2180;   // same index, tag 0x21
    drive_cycle('0, branch_upd(a, 1'b1, 32'h0000_4000, 1'b0));
    drive_cycle(look_req(a), '0);   // hit and redirect
    check_val("pred_o.next_pc of a", pred.next_pc, 32'h0000_4000);
    drive_cycle(look_req(b), '0);   // tag differs so it misses
    drive_cycle('0, branch_upd(b, 1'b1, 32'h0000_5000, 1'b0));   // evicts a
    drive_cycle(look_req(a), '0);
    check_val("pred_o.btb_hit of a after evict", 32'(pred.btb_hit), 32'd0);
    drive_cycle(look_req(b), '0);
    end_test("btb_target");
  endtask

  task automatic same_cycle_test();
    addr_t c;
    c = 32'h0000_3100;
    // lookup sees old state
    drive_cycle(look_req(c), branch_upd(c, 1'b1, 32'h0000_6000, 1'b0));
    drive_cycle(look_req(c), '0);   // now taken with a hit
    end_test("same_cycle");
  endtask

  task automatic random_mix_test();
    addr_t   r;
    addr_t   tgt;
    addr_t   pc;
    pred_s   cur;
    lookup_s lk;
    update_s up;
    pool[0] = 32'h0000_0100;
    pool[1] = 32'h0000_0200;   // btb index shared with 0x100
    pool[2] = 32'h0001_0100;   // both indices shared with 0x100
    pool[3] = 32'h0000_0104;
    pool[4] = 32'h0000_0300;
    pool[5] = 32'h0002_0204;   // btb index shared with 0x104
    pool[6] = 32'h0000_0500;
    pool[7] = 32'h0000_0108;
    for (int i = 0; i < 400; i++)
    begin
      r  = $random(seed);
      lk = '0;
      up = '0;
      if (r[0])
        lk = look_req(pool[r[4:2]]);
      if (r[1])
      begin
        pc  = pool[r[7:5]];
        tgt = $random(seed);
        cur = ref_pred(pc);   // back end reports what was predicted
        up  = branch_upd(pc, r[8], {tgt[31:2], 2'b00}, cur.taken);
      end
      drive_cycle(lk, up);
    end
    end_test("random_mix");
  endtask

  initial
  begin
    seed      = 24396;
    err_cnt   = 0;
    check_cnt = 0;
    test_cnt  = 0;
    test_err0 = 0;
    reset_i   = 1'b1;
    lookup    = '0;
    update    = '0;
    model_reset();
    repeat (3) @(negedge clk_i);   // three rising edges in reset
    reset_i = 1'b0;

    reset_state_test();
    counter_train_test();
    btb_target_test();
    same_cycle_test();
    random_mix_test();

    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

/* all.f */
source/fe_pkg.sv
source/fe_bht.sv
source/fe_btb.sv
source/fe_pred_ctrl.sv
source/fe_predictor_top.sv
bench/fe_predictor_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds and runs the predictor testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log" build.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module fe_predictor_tb -f all.f -o fe_predictor_sim > build.log 2>&1 \
  && ./obj_dir/fe_predictor_sim > "$log" 2>&1 \
  || { echo "build or simulation did not complete"; cat build.log "$log" 2>/dev/null; exit 1; }

cat "$log"

# the log decides the result
grep -qF "*** FAILED ***" "$log" \
  && { echo "simulation reported failure"; exit 1; } \
  || { echo "no failure found in $log"; exit 0; }
